// File: logic/cdsys_pkg.sv
//====================================================================
// Shared definitions for the transfer controller
// Bus widths, host register offsets, area and DMA mode codes,
// microcode words and the data word union
//====================================================================

package cdsys_pkg;

	localparam int ADDR_W  = 23;          // Host word address
	localparam int BADDR_W = ADDR_W + 1;  // Byte address used by the DMA
	localparam int DATA_W  = 16;
	localparam int UP_W    = 19;          // Upload zone word address
	localparam int AREA_W  = 3;
	localparam int MODE_W  = 3;

	//================================================================
	// Host register map, word offsets inside the FF0000 page
	//================================================================
	localparam logic [ADDR_W-9:0] REG_PAGE = 15'h7F80;
	localparam logic [7:0] REG_START     = 8'h30;  // FF0061, low byte
	localparam logic [7:0] REG_ADDR_A_HI = 8'h32;
	localparam logic [7:0] REG_ADDR_A_LO = 8'h33;
	localparam logic [7:0] REG_ADDR_B_HI = 8'h34;
	localparam logic [7:0] REG_ADDR_B_LO = 8'h35;
	localparam logic [7:0] REG_VALUE_HI  = 8'h36;
	localparam logic [7:0] REG_COUNT_HI  = 8'h38;
	localparam logic [7:0] REG_COUNT_LO  = 8'h39;
	localparam logic [7:0] REG_UCODE0    = 8'h3F;
	localparam logic [7:0] REG_AREA_SEL  = 8'h82;
	localparam logic [7:0] REG_MAP_SPR   = 8'h90;
	localparam logic [7:0] REG_MAP_PCM   = 8'h91;
	localparam logic [7:0] REG_MAP_Z80   = 8'h93;
	localparam logic [7:0] REG_MAP_FIX   = 8'h94;
	localparam logic [7:0] REG_UNMAP_SPR = 8'hA0;
	localparam logic [7:0] REG_UNMAP_PCM = 8'hA1;
	localparam logic [7:0] REG_UNMAP_Z80 = 8'hA3;
	localparam logic [7:0] REG_UNMAP_FIX = 8'hA4;
	localparam int START_BIT = 6;

	localparam logic [3:0] UPLOAD_NIBBLE = 4'hE;

	// Upload areas
	localparam logic [AREA_W-1:0] AREA_SPR  = 3'd0;
	localparam logic [AREA_W-1:0] AREA_PCM  = 3'd1;
	localparam logic [AREA_W-1:0] AREA_Z80  = 3'd4;
	localparam logic [AREA_W-1:0] AREA_FIX  = 3'd5;
	localparam logic [AREA_W-1:0] AREA_NONE = 3'd3;  // Selected area not mapped
	localparam logic [AREA_W-1:0] AREA_CUR  = 3'd7;  // Follow the host area select

	// DMA modes
	localparam logic [MODE_W-1:0] MODE_CD_WORD   = 3'd0;
	localparam logic [MODE_W-1:0] MODE_CD_BYTE   = 3'd1;
	localparam logic [MODE_W-1:0] MODE_COPY_WORD = 3'd2;
	localparam logic [MODE_W-1:0] MODE_FILL      = 3'd4;

	// First microcode word of each known program
	localparam logic [DATA_W-1:0] UCODE_CD_WORD_A = 16'hFF89;
	localparam logic [DATA_W-1:0] UCODE_CD_WORD_B = 16'hFFC5;
	localparam logic [DATA_W-1:0] UCODE_CD_BYTE   = 16'hFC2D;
	localparam logic [DATA_W-1:0] UCODE_COPY_A    = 16'hFE6D;
	localparam logic [DATA_W-1:0] UCODE_COPY_B    = 16'hFE3D;
	localparam logic [DATA_W-1:0] UCODE_FILL_A    = 16'hFFCD;
	localparam logic [DATA_W-1:0] UCODE_FILL_B    = 16'hFFDD;

	typedef union packed {
		logic [DATA_W-1:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} data_word_u;

endpackage

// File: logic/xfer_bus_if.sv
//====================================================================
// Request and grant link between one requester and the arbiter
//====================================================================

`timescale 1ns/10ps

interface xfer_bus_if import cdsys_pkg::*; ();

	logic req;                 // Held until gnt
	logic wr;                  // Write to the upload zone this cycle
	logic [UP_W-1:0] addr;
	logic [DATA_W-1:0] data;
	logic [AREA_W-1:0] area;
	logic gnt;

	modport requester (
		output req, wr, addr, data, area,
		input  gnt
	);

	modport arbiter (
		input  req, wr, addr, data, area,
		output gnt
	);

endinterface

// File: logic/host_regs.sv
//====================================================================
// Host register block
// DMA setup registers, microcode to mode decode, start pulse
// Upload area select and map flags, direct upload requests
//====================================================================

`timescale 1ns/10ps

module host_regs import cdsys_pkg::*; #(
	parameter int COUNT_W = 24
) (
	input  logic clk_sys,
	input  logic nRESET,
	input  logic host_wr,
	input  logic [ADDR_W-1:0] host_addr,
	input  logic [DATA_W-1:0] host_wdata,
	input  logic [1:0] host_be,
	xfer_bus_if.requester host_bus,
	output logic [BADDR_W-1:0] addr_a,
	output logic [BADDR_W-1:0] addr_b,
	output logic [DATA_W-1:0] fill_value,
	output logic [COUNT_W-1:0] count,
	output logic [MODE_W-1:0] mode,
	output logic start
);

	logic [7:0] offs;
	logic reg_zone;
	logic up_zone;
	logic accept;
	logic word_wr;
	logic byte_wr;
	logic [AREA_W-1:0] area_sel;
	logic use_spr, use_pcm, use_z80, use_fix;
	logic area_ok;
	logic [DATA_W-1:0] ucode0;

	assign offs     = host_addr[7:0];
	assign reg_zone = host_addr[ADDR_W-1:8] == REG_PAGE;
	assign up_zone  = host_addr[ADDR_W-1 -: 4] == UPLOAD_NIBBLE;
	assign accept   = host_wr & host_bus.gnt;
	assign word_wr  = accept & reg_zone & (&host_be);
	assign byte_wr  = accept & reg_zone & host_be[0];  // Odd byte registers

	always_comb
	begin
		case (area_sel)
			AREA_SPR: area_ok = use_spr;
			AREA_PCM: area_ok = use_pcm;
			AREA_Z80: area_ok = use_z80;
			AREA_FIX: area_ok = use_fix;
			default:  area_ok = 1'b0;
		endcase
	end

	// Every host write asks for the bus, only mapped uploads write
	assign host_bus.req  = host_wr;
	assign host_bus.wr   = host_wr & up_zone & area_ok & (|host_be);
	assign host_bus.addr = host_addr[UP_W-1:0];
	assign host_bus.data = host_wdata;
	assign host_bus.area = area_ok ? area_sel : AREA_NONE;  // Also used by DMA writes

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			area_sel <= AREA_SPR;
			use_spr  <= 1'b0;
			use_pcm  <= 1'b0;
			use_z80  <= 1'b0;
			use_fix  <= 1'b0;
			mode     <= MODE_CD_WORD;
			start    <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			if (byte_wr)
			begin
				case (offs)
					REG_START:
						if (host_wdata[START_BIT])
						begin
							start <= 1'b1;
							case (ucode0)
								UCODE_CD_WORD_A, UCODE_CD_WORD_B: mode <= MODE_CD_WORD;
								UCODE_CD_BYTE:                    mode <= MODE_CD_BYTE;
								UCODE_COPY_A, UCODE_COPY_B:       mode <= MODE_COPY_WORD;
								UCODE_FILL_A, UCODE_FILL_B:       mode <= MODE_FILL;
								default: ;                        // Unknown program
							endcase
						end
					REG_AREA_SEL:  area_sel <= host_wdata[AREA_W-1:0];
					REG_MAP_SPR:   use_spr <= 1'b1;
					REG_MAP_PCM:   use_pcm <= 1'b1;
					REG_MAP_Z80:   use_z80 <= 1'b1;
					REG_MAP_FIX:   use_fix <= 1'b1;
					REG_UNMAP_SPR: use_spr <= 1'b0;
					REG_UNMAP_PCM: use_pcm <= 1'b0;
					REG_UNMAP_Z80: use_z80 <= 1'b0;
					REG_UNMAP_FIX: use_fix <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	// DMA setup words
	always_ff @(posedge clk_sys)
	begin
		if (word_wr)
		begin
			case (offs)
				REG_ADDR_A_HI: addr_a[BADDR_W-1:16] <= host_wdata[BADDR_W-17:0];
				REG_ADDR_A_LO: addr_a[15:0] <= host_wdata;
				REG_ADDR_B_HI: addr_b[BADDR_W-1:16] <= host_wdata[BADDR_W-17:0];
				REG_ADDR_B_LO: addr_b[15:0] <= host_wdata;
				REG_VALUE_HI:  fill_value <= host_wdata;
				REG_COUNT_HI:  count[COUNT_W-1:16] <= host_wdata[COUNT_W-17:0];
				REG_COUNT_LO:  count[15:0] <= host_wdata;
				REG_UCODE0:    ucode0 <= host_wdata;
				default: ;
			endcase
		end
	end

endmodule

// File: logic/sector_cache.sv
//====================================================================
// Double-banked sector cache
// Drive side load into the write bank, one-cycle read port,
// sector pacing timer, bank swap and credit return
//====================================================================

`timescale 1ns/10ps

module sector_cache import cdsys_pkg::*; #(
	parameter int SECTOR_WORDS  = 1024,
	parameter int SECTOR_CYCLES = 20000
) (
	input  logic clk_sys,
	input  logic nRESET,
	input  logic cd_wr,
	input  logic [$clog2(SECTOR_WORDS)-1:0] cd_addr,
	input  logic [DATA_W-1:0] cd_din,
	input  logic [$clog2(SECTOR_WORDS)-1:0] rd_addr,
	output logic [DATA_W-1:0] rd_data,
	output logic cd_credit,
	output logic sector_ready
);

	localparam int AW = $clog2(SECTOR_WORDS);
	localparam int TW = $clog2(SECTOR_CYCLES + 1);

	logic [DATA_W-1:0] mem [2*SECTOR_WORDS];
	logic [1:0] filled;
	logic rd_bank;
	logic wr_bank;
	logic rd_live;       // Reader has been handed a bank
	logic [AW-1:0] wr_cnt;
	logic [TW-1:0] timer;
	logic timer_done;
	logic swap;
	logic sector_end;

	assign timer_done = timer == TW'(SECTOR_CYCLES);
	assign swap       = timer_done & filled[~rd_bank];
	assign sector_end = cd_wr & (wr_cnt == AW'(SECTOR_WORDS - 1));

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			filled       <= 2'b00;
			rd_bank      <= 1'b1;   // First sector lands in bank 0
			wr_bank      <= 1'b0;
			rd_live      <= 1'b0;
			wr_cnt       <= '0;
			timer        <= '0;
			cd_credit    <= 1'b0;
			sector_ready <= 1'b0;
		end
		else
		begin
			sector_ready <= swap;
			cd_credit    <= swap & rd_live & filled[rd_bank];

			//========================================================
			// Pacing and swap
			//========================================================
			if (swap)
			begin
				timer   <= '0;
				rd_bank <= ~rd_bank;
				rd_live <= 1'b1;
				if (rd_live)
					filled[rd_bank] <= 1'b0;  // Old read bank back to the drive
			end
			else if (!timer_done)
				timer <= timer + 1'b1;

			// Load side
			if (cd_wr)
				wr_cnt <= sector_end ? '0 : wr_cnt + 1'b1;
			if (sector_end)
			begin
				filled[wr_bank] <= 1'b1;
				wr_bank <= ~wr_bank;
			end
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (cd_wr)
			mem[{wr_bank, cd_addr}] <= cd_din;
		rd_data <= mem[{rd_bank, rd_addr}];
	end

endmodule

// File: logic/dma_engine.sv
//====================================================================
// DMA engine
// Cache word copy, cache byte copy, memory word copy and word fill,
// writes go out through the shared transfer bus
//====================================================================

`timescale 1ns/10ps

module dma_engine import cdsys_pkg::*; #(
	parameter int SECTOR_WORDS = 1024,
	parameter int COUNT_W      = 24
) (
	input  logic clk_sys,
	input  logic nRESET,
	input  logic [BADDR_W-1:0] addr_a,
	input  logic [BADDR_W-1:0] addr_b,
	input  logic [DATA_W-1:0] fill_value,
	input  logic [COUNT_W-1:0] count,
	input  logic [MODE_W-1:0] mode,
	input  logic start,
	output logic [$clog2(SECTOR_WORDS)-1:0] rd_addr,
	input  logic [DATA_W-1:0] rd_data,
	output logic mem_rd,
	output logic [BADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_rdata,
	input  logic mem_rvalid,
	input  logic mem_busy,
	xfer_bus_if.requester dma_bus,
	output logic dma_running
);

	localparam int AW = $clog2(SECTOR_WORDS);

	localparam logic [2:0] ST_IDLE  = 3'd0;
	localparam logic [2:0] ST_CRD   = 3'd1;  // Cache address out
	localparam logic [2:0] ST_CWAIT = 3'd2;  // Cache data back
	localparam logic [2:0] ST_MRD   = 3'd3;
	localparam logic [2:0] ST_MWAIT = 3'd4;
	localparam logic [2:0] ST_WR    = 3'd5;
	localparam logic [2:0] ST_WR2   = 3'd6;  // Second write of byte mode

	logic [2:0] state;
	logic [2:0] loop_st;
	logic [COUNT_W-1:0] remain;
	logic [BADDR_W-1:0] src;
	logic [BADDR_W-1:0] dst;
	logic [AW-1:0] rd_ptr;
	data_word_u dq;
	logic writing;
	logic last_wr;

	// Where each count starts
	always_comb
	begin
		case (mode)
			MODE_CD_WORD, MODE_CD_BYTE: loop_st = ST_CRD;
			MODE_COPY_WORD:             loop_st = ST_MRD;
			default:                    loop_st = ST_WR;
		endcase
	end

	assign writing = (state == ST_WR) | (state == ST_WR2);
	assign last_wr = (state == ST_WR2) | (mode != MODE_CD_BYTE);

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			state       <= ST_IDLE;
			dma_running <= 1'b0;
			remain      <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (start && count != '0)
					begin
						dma_running <= 1'b1;
						remain  <= count;
						src     <= addr_a;
						dst     <= (mode == MODE_COPY_WORD) ? addr_b : addr_a;
						rd_ptr  <= '0;
						dq.word <= fill_value;
						state   <= loop_st;
					end
				ST_CRD: state <= ST_CWAIT;
				ST_CWAIT:
				begin
					dq.word <= rd_data;
					rd_ptr  <= rd_ptr + 1'b1;
					state   <= ST_WR;
				end
				ST_MRD:
					if (!mem_busy)
					begin
						src   <= src + BADDR_W'(2);  // Read issued this cycle
						state <= ST_MWAIT;
					end
				ST_MWAIT:
					if (mem_rvalid)
					begin
						dq.word <= mem_rdata;
						state   <= ST_WR;
					end
				ST_WR, ST_WR2:
					if (dma_bus.gnt)
					begin
						dst <= dst + BADDR_W'(2);
						if (!last_wr)
							state <= ST_WR2;
						else if (remain == COUNT_W'(1))
						begin
							dma_running <= 1'b0;
							state <= ST_IDLE;
						end
						else
						begin
							remain <= remain - 1'b1;
							state  <= loop_st;
						end
					end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign rd_addr  = rd_ptr;
	assign mem_rd   = (state == ST_MRD) & ~mem_busy;
	assign mem_addr = src;

	//================================================================
	// Transfer bus side
	//================================================================
	assign dma_bus.req  = dma_running;  // Held for the whole job
	assign dma_bus.wr   = writing & (dst[BADDR_W-1 -: 4] == UPLOAD_NIBBLE);
	assign dma_bus.addr = dst[UP_W:1];
	assign dma_bus.data = ((state == ST_WR) && (mode == MODE_CD_BYTE)) ?
	                      {dq.bytes.lo, dq.bytes.hi} : dq.word;
	assign dma_bus.area = AREA_CUR;

endmodule

// File: logic/xfer_arbiter.sv
//====================================================================
// Transfer bus arbiter
// Grant between host and DMA engine, registered write and area strobes
//====================================================================

`timescale 1ns/10ps

module xfer_arbiter import cdsys_pkg::*; (
	input  logic clk_sys,
	input  logic nRESET,
	xfer_bus_if.arbiter host_bus,
	xfer_bus_if.arbiter dma_bus,
	output logic host_ready,
	output logic [UP_W-1:0] tr_addr,
	output logic [DATA_W-1:0] tr_data,
	output logic tr_wr_spr,
	output logic tr_wr_pcm,
	output logic tr_wr_z80,
	output logic tr_wr_fix
);

	logic own_host;     // Host held the bus last cycle
	logic gnt_host, gnt_dma;
	logic wr_host, wr_dma;
	logic any_wr;
	logic [AREA_W-1:0] area;

	// DMA wins unless the host is mid-burst, and keeps the bus while it requests
	assign gnt_dma      = dma_bus.req & ~(own_host & host_bus.req);
	assign gnt_host     = host_bus.req & ~gnt_dma;
	assign dma_bus.gnt  = gnt_dma;
	assign host_bus.gnt = gnt_host;
	assign host_ready   = ~gnt_dma;

	// wr is only raised for addresses in the upload zone
	assign wr_dma  = gnt_dma & dma_bus.wr;
	assign wr_host = gnt_host & host_bus.wr;
	assign any_wr  = wr_dma | wr_host;
	assign area    = (wr_dma && dma_bus.area != AREA_CUR) ? dma_bus.area : host_bus.area;

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			own_host  <= 1'b0;
			tr_wr_spr <= 1'b0;
			tr_wr_pcm <= 1'b0;
			tr_wr_z80 <= 1'b0;
			tr_wr_fix <= 1'b0;
		end
		else
		begin
			own_host  <= gnt_host;
			tr_wr_spr <= any_wr & (area == AREA_SPR);
			tr_wr_pcm <= any_wr & (area == AREA_PCM);
			tr_wr_z80 <= any_wr & (area == AREA_Z80);
			tr_wr_fix <= any_wr & (area == AREA_FIX);
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (wr_dma)
		begin
			tr_addr <= dma_bus.addr;
			tr_data <= dma_bus.data;
		end
		else if (wr_host)
		begin
			tr_addr <= host_bus.addr;
			tr_data <= host_bus.data;
		end
	end

endmodule

// File: logic/cd_xfer_top.sv
//====================================================================
// Transfer side of the CD system controller
// Host registers, sector cache, DMA engine and bus arbiter
//====================================================================

`timescale 1ns/10ps

module cd_xfer_top import cdsys_pkg::*; #(
	parameter int SECTOR_WORDS  = 1024,
	parameter int SECTOR_CYCLES = 20000,
	parameter int COUNT_W       = 24
) (
	input  logic clk_sys,
	input  logic nRESET,
	// Host port
	input  logic host_wr,
	input  logic [ADDR_W-1:0] host_addr,
	input  logic [DATA_W-1:0] host_wdata,
	input  logic [1:0] host_be,
	output logic host_ready,
	// Drive side
	input  logic cd_wr,
	input  logic [$clog2(SECTOR_WORDS)-1:0] cd_addr,
	input  logic [DATA_W-1:0] cd_din,
	output logic cd_credit,
	output logic sector_ready,
	// Memory read port
	output logic mem_rd,
	output logic [BADDR_W-1:0] mem_addr,
	input  logic [DATA_W-1:0] mem_rdata,
	input  logic mem_rvalid,
	input  logic mem_busy,
	// Upload areas
	output logic [UP_W-1:0] tr_addr,
	output logic [DATA_W-1:0] tr_data,
	output logic tr_wr_spr,
	output logic tr_wr_pcm,
	output logic tr_wr_z80,
	output logic tr_wr_fix,
	output logic dma_running
);

	logic [BADDR_W-1:0] addr_a;
	logic [BADDR_W-1:0] addr_b;
	logic [DATA_W-1:0] fill_value;
	logic [COUNT_W-1:0] count;
	logic [MODE_W-1:0] mode;
	logic start;
	logic [$clog2(SECTOR_WORDS)-1:0] rd_addr;
	logic [DATA_W-1:0] rd_data;

	xfer_bus_if host_bus ();
	xfer_bus_if dma_bus ();

	host_regs #(.COUNT_W(COUNT_W)) u_regs (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.host_wr(host_wr), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_be(host_be),
		.host_bus(host_bus.requester),
		.addr_a(addr_a), .addr_b(addr_b), .fill_value(fill_value),
		.count(count), .mode(mode), .start(start)
	);

	sector_cache #(
		.SECTOR_WORDS(SECTOR_WORDS),
		.SECTOR_CYCLES(SECTOR_CYCLES)
	) u_cache (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.cd_wr(cd_wr), .cd_addr(cd_addr), .cd_din(cd_din),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.cd_credit(cd_credit), .sector_ready(sector_ready)
	);

	dma_engine #(
		.SECTOR_WORDS(SECTOR_WORDS),
		.COUNT_W(COUNT_W)
	) u_dma (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.addr_a(addr_a), .addr_b(addr_b), .fill_value(fill_value),
		.count(count), .mode(mode), .start(start),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.mem_rd(mem_rd), .mem_addr(mem_addr), .mem_rdata(mem_rdata),
		.mem_rvalid(mem_rvalid), .mem_busy(mem_busy),
		.dma_bus(dma_bus.requester),
		.dma_running(dma_running)
	);

	xfer_arbiter u_arb (
		.clk_sys(clk_sys), .nRESET(nRESET),
		.host_bus(host_bus.arbiter), .dma_bus(dma_bus.arbiter),
		.host_ready(host_ready),
		.tr_addr(tr_addr), .tr_data(tr_data),
		.tr_wr_spr(tr_wr_spr), .tr_wr_pcm(tr_wr_pcm),
		.tr_wr_z80(tr_wr_z80), .tr_wr_fix(tr_wr_fix)
	);

endmodule

// File: testbench/cd_xfer_chk.sv
//====================================================================
// Concurrent assertions on the transfer controller ports
// Strobe one-hot, upload zone, credit count, host_ready during DMA
//====================================================================

`timescale 1ns/10ps

module cd_xfer_chk import cdsys_pkg::*; #(
	parameter int SECTOR_WORDS = 16
) (
	input logic clk_sys,
	input logic nRESET,
	input logic host_wr,
	input logic [ADDR_W-1:0] host_addr,
	input logic host_ready,
	input logic cd_wr,
	input logic cd_credit,
	input logic tr_wr_spr,
	input logic tr_wr_pcm,
	input logic tr_wr_z80,
	input logic tr_wr_fix,
	input logic dma_running
);

	int words_in;
	int credits_out;
	logic any_strobe;

	assign any_strobe = tr_wr_spr | tr_wr_pcm | tr_wr_z80 | tr_wr_fix;

	always_ff @(posedge clk_sys)
	begin
		if (!nRESET)
		begin
			words_in    <= 0;
			credits_out <= 0;
		end
		else
		begin
			if (cd_wr)
				words_in <= words_in + 1;
			if (cd_credit)
				credits_out <= credits_out + 1;
		end
	end

	strobe_onehot: assert property (@(posedge clk_sys) disable iff (!nRESET)
		$onehot0({tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix}))
		else $error("More than one area strobe active");

	// Host upload zone write or a DMA job one cycle before
	strobe_zone: assert property (@(posedge clk_sys) disable iff (!nRESET)
		any_strobe |-> $past((host_wr && host_addr[ADDR_W-1 -: 4] == UPLOAD_NIBBLE)
		                     || dma_running))
		else $error("Area strobe without an upload zone write");

	credit_bound: assert property (@(posedge clk_sys) disable iff (!nRESET)
		credits_out <= words_in / SECTOR_WORDS)
		else $error("More credits returned than sectors loaded");

	host_blocked: assert property (@(posedge clk_sys) disable iff (!nRESET)
		dma_running |-> !host_ready)
		else $error("host_ready high during a DMA job");

endmodule

bind cd_xfer_top cd_xfer_chk #(.SECTOR_WORDS(SECTOR_WORDS)) chk (
	.clk_sys(clk_sys), .nRESET(nRESET),
	.host_wr(host_wr), .host_addr(host_addr), .host_ready(host_ready),
	.cd_wr(cd_wr), .cd_credit(cd_credit),
	.tr_wr_spr(tr_wr_spr), .tr_wr_pcm(tr_wr_pcm),
	.tr_wr_z80(tr_wr_z80), .tr_wr_fix(tr_wr_fix),
	.dma_running(dma_running)
);

// File: testbench/tb_cd_xfer.sv
//====================================================================
// Testbench for the transfer controller
// Clock, reset, memory model, job table, checks and reporting
//====================================================================

`timescale 1ns/10ps

module tb_cd_xfer import cdsys_pkg::*; ;

	localparam int SW    = 16;
	localparam int SC    = 64;
	localparam int CW    = 24;
	localparam int AW    = $clog2(SW);
	localparam int NROWS = 4;

	logic clk_sys = 1'b0;
	logic nRESET;
	logic host_wr;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata;
	logic [1:0] host_be;
	logic host_ready;
	logic cd_wr;
	logic [AW-1:0] cd_addr;
	logic [DATA_W-1:0] cd_din;
	logic cd_credit, sector_ready;
	logic mem_rd;
	logic [BADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_rdata;
	logic mem_rvalid, mem_busy;
	logic [UP_W-1:0] tr_addr;
	logic [DATA_W-1:0] tr_data;
	logic tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix;
	logic dma_running;

	// Job table
	logic [MODE_W-1:0] row_mode [NROWS];
	logic [BADDR_W-1:0] row_a [NROWS];
	logic [BADDR_W-1:0] row_b [NROWS];
	logic [DATA_W-1:0] row_value [NROWS];
	int row_count [NROWS];
	logic [AREA_W-1:0] row_area [NROWS];

	logic [37:0] strobes [$];  // Area, address, data
	int errors, tests_pass, tests_fail;
	int cycles, limit;
	int sr_count, credit_count, sectors_loaded;
	logic rd_pend;
	logic [BADDR_W-1:0] rd_src;
	int rd_lat;

	cd_xfer_top #(.SECTOR_WORDS(SW), .SECTOR_CYCLES(SC), .COUNT_W(CW)) uut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
	begin
		cycles = cycles + 1;
		if (cycles >= limit)
		begin
			$display("Timeout after %0d cycles, a DUT handshake never completed", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//================================================================
	// Monitors and memory model
	//================================================================
	always @(negedge clk_sys)
	begin
		if (tr_wr_spr)
			strobes.push_back({AREA_SPR, tr_addr, tr_data});
		else if (tr_wr_pcm)
			strobes.push_back({AREA_PCM, tr_addr, tr_data});
		else if (tr_wr_z80)
			strobes.push_back({AREA_Z80, tr_addr, tr_data});
		else if (tr_wr_fix)
			strobes.push_back({AREA_FIX, tr_addr, tr_data});
		if (sector_ready)
			sr_count = sr_count + 1;
		if (cd_credit)
		begin
			credit_count = credit_count + 1;
			if (!sector_ready)
			begin
				$display("cd_credit pulsed outside a bank swap at %0t", $time);
				errors = errors + 1;
			end
		end
		if (mem_rd)
		begin
			if (rd_pend || mem_busy)
			begin
				$display("Memory read issued while busy or pending at %0t", $time);
				errors = errors + 1;
			end
			rd_pend = 1'b1;
			rd_src  = mem_addr;
			rd_lat  = 1 + int'($urandom % 4);
		end
	end

	always @(posedge clk_sys)
	begin
		mem_busy   <= ($urandom % 3) == 0;
		mem_rvalid <= 1'b0;
		if (rd_pend)
		begin
			if (rd_lat == 1)
			begin
				mem_rvalid <= 1'b1;
				mem_rdata  <= rd_src[15:0] ^ 16'h5A5A;
				rd_pend = 1'b0;
			end
			else
				rd_lat = rd_lat - 1;
		end
	end

	//================================================================
	// Helpers
	//================================================================
	function automatic logic [DATA_W-1:0] sector_word(input int s, input int i);
		return {4'(s + 1), 4'(i), 8'(i) ^ 8'h3C};
	endfunction

	function automatic logic [7:0] map_offs(input logic [AREA_W-1:0] area, input logic on);
		case (area)
			AREA_PCM: return on ? REG_MAP_PCM : REG_UNMAP_PCM;
			AREA_Z80: return on ? REG_MAP_Z80 : REG_UNMAP_Z80;
			AREA_FIX: return on ? REG_MAP_FIX : REG_UNMAP_FIX;
			default:  return on ? REG_MAP_SPR : REG_UNMAP_SPR;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] ucode_for(input logic [MODE_W-1:0] m);
		case (m)
			MODE_CD_BYTE:   return UCODE_CD_BYTE;
			MODE_COPY_WORD: return UCODE_COPY_A;
			MODE_FILL:      return UCODE_FILL_A;
			default:        return UCODE_CD_WORD_A;
		endcase
	endfunction

	// Expected data of write k, the read bank holds sector 1
	function automatic logic [DATA_W-1:0] expected_data(input int r, input int k);
		logic [DATA_W-1:0] w;
		logic [BADDR_W-1:0] src;
		w   = sector_word(1, k / 2);
		src = row_a[r] + BADDR_W'(2 * k);
		case (row_mode[r])
			MODE_FILL:      return row_value[r];
			MODE_CD_WORD:   return sector_word(1, k);
			MODE_CD_BYTE:   return (k % 2 == 0) ? {w[7:0], w[15:8]} : w;
			default:        return src[15:0] ^ 16'h5A5A;
		endcase
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic report(input string name, input int start_err);
		if (errors == start_err)
		begin
			tests_pass = tests_pass + 1;
			$display("PASS %s", name);
		end
		else
		begin
			tests_fail = tests_fail + 1;
			$display("FAIL %s", name);
		end
	endtask

	// Holds host_wr until host_ready is seen
	task automatic host_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
	                          input logic [1:0] be);
		@(posedge clk_sys);
		host_wr    <= 1'b1;
		host_addr  <= a;
		host_wdata <= d;
		host_be    <= be;
		@(negedge clk_sys);
		while (!host_ready)
			@(negedge clk_sys);
		@(posedge clk_sys);
		host_wr <= 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] offs, input logic [DATA_W-1:0] d);
		host_write({REG_PAGE, offs}, d, 2'b11);
	endtask

	task automatic map_area(input logic [AREA_W-1:0] area);
		reg_write(REG_AREA_SEL, DATA_W'(area));
		reg_write(map_offs(area, 1'b1), 16'h0000);
	endtask

	task automatic load_sector(input int s);
		if (2 + credit_count - sectors_loaded <= 0)
		begin
			$display("Drive source has no credit for sector %0d", s);
			errors = errors + 1;
		end
		for (int i = 0; i < SW; i++)
		begin
			@(posedge clk_sys);
			cd_wr   <= 1'b1;
			cd_addr <= AW'(i);
			cd_din  <= sector_word(s, i);
		end
		@(posedge clk_sys);
		cd_wr <= 1'b0;
		sectors_loaded = sectors_loaded + 1;
	endtask

	task automatic wait_swaps(input int n);
		while (sr_count < n)
			@(negedge clk_sys);
		@(posedge clk_sys);
	endtask

	task automatic set_row(input int r, input logic [MODE_W-1:0] m, input logic [BADDR_W-1:0] a,
	                       input logic [BADDR_W-1:0] b, input logic [DATA_W-1:0] v,
	                       input int c, input logic [AREA_W-1:0] area);
		row_mode[r]  = m;
		row_a[r]     = a;
		row_b[r]     = b;
		row_value[r] = v;
		row_count[r] = c;
		row_area[r]  = area;
	endtask

	task automatic run_row(input int r);
		int start_err;
		int n;
		logic [BADDR_W-1:0] dst;
		logic [37:0] s;
		start_err = errors;
		map_area(row_area[r]);
		reg_write(REG_ADDR_A_HI, {8'h00, row_a[r][23:16]});
		reg_write(REG_ADDR_A_LO, row_a[r][15:0]);
		reg_write(REG_ADDR_B_HI, {8'h00, row_b[r][23:16]});
		reg_write(REG_ADDR_B_LO, row_b[r][15:0]);
		reg_write(REG_VALUE_HI, row_value[r]);
		reg_write(REG_COUNT_HI, 16'h0000);
		reg_write(REG_COUNT_LO, 16'(row_count[r]));
		reg_write(REG_UCODE0, ucode_for(row_mode[r]));
		strobes.delete();
		host_write({REG_PAGE, REG_START}, 16'h0040, 2'b01);
		while (!dma_running)
			@(negedge clk_sys);
		while (dma_running)
			@(negedge clk_sys);
		if (!host_ready)
		begin
			$display("host_ready stayed low after DMA job %0d", r);
			errors = errors + 1;
		end
		repeat (2) @(posedge clk_sys);
		n   = (row_mode[r] == MODE_CD_BYTE) ? 2 * row_count[r] : row_count[r];
		dst = (row_mode[r] == MODE_COPY_WORD) ? row_b[r] : row_a[r];
		if (strobes.size() != n)
		begin
			$display("DMA job %0d gave %0d strobes instead of %0d", r, strobes.size(), n);
			errors = errors + 1;
		end
		else
			for (int k = 0; k < n; k++)
			begin
				s = strobes[k];
				check("area", 32'(s[37:35]), 32'(row_area[r]));
				check("tr_addr", 32'(s[34:16]), 32'(UP_W'(dst[BADDR_W-1:1] + (BADDR_W-1)'(k))));
				check("tr_data", 32'(s[15:0]), 32'(expected_data(r, k)));
			end
		report($sformatf("DMA job %0d mode %0d", r, row_mode[r]), start_err);
	endtask

	//================================================================
	// Main sequence
	//================================================================
	initial
	begin
		int start_err;
		int total;
		void'($urandom(56));
		nRESET = 1'b0;
		host_wr = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_be = 2'b00;
		cd_wr = 1'b0;
		cd_addr = '0;
		cd_din = '0;
		mem_rdata = '0;
		mem_rvalid = 1'b0;
		mem_busy = 1'b0;
		rd_pend = 1'b0;
		rd_src = '0;
		rd_lat = 0;
		errors = 0;
		tests_pass = 0;
		tests_fail = 0;
		cycles = 0;
		sr_count = 0;
		credit_count = 0;
		sectors_loaded = 0;
		set_row(0, MODE_FILL, 24'hE00100, 24'h000000, 16'hC3A5, 6, AREA_SPR);
		set_row(1, MODE_COPY_WORD, 24'h012340, 24'hE40000, 16'h0000, 6, AREA_Z80);
		set_row(2, MODE_CD_WORD, 24'hE80000, 24'h000000, 16'h0000, SW / 2, AREA_FIX);
		set_row(3, MODE_CD_BYTE, 24'hEA0010, 24'h000000, 16'h0000, 4, AREA_SPR);
		total = 0;
		for (int r = 0; r < NROWS; r++)
			total = total + row_count[r];
		limit = total * 12 + 2 * SC + NROWS * 80 + 300;  // Setup writes and loads included

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		start_err = errors;
		check("dma_running", 32'(dma_running), 0);
		check("sector_ready", 32'(sector_ready), 0);
		check("cd_credit", 32'(cd_credit), 0);
		check("mem_rd", 32'(mem_rd), 0);
		check("strobes", 32'({tr_wr_spr, tr_wr_pcm, tr_wr_z80, tr_wr_fix}), 0);
		check("host_ready", 32'(host_ready), 1);
		report("reset state", start_err);
		@(posedge clk_sys);
		nRESET <= 1'b1;

		// Direct upload, mapped then unmapped
		start_err = errors;
		map_area(AREA_PCM);
		strobes.delete();
		host_write({UPLOAD_NIBBLE, 19'h00123}, 16'hBEEF, 2'b11);
		repeat (3) @(posedge clk_sys);
		if (strobes.size() != 1)
		begin
			$display("Mapped upload gave %0d strobes instead of 1", strobes.size());
			errors = errors + 1;
		end
		else
		begin
			check("area", 32'(strobes[0][37:35]), 32'(AREA_PCM));
			check("tr_addr", 32'(strobes[0][34:16]), 32'h00123);
			check("tr_data", 32'(strobes[0][15:0]), 32'hBEEF);
		end
		reg_write(map_offs(AREA_PCM, 1'b0), 16'h0000);
		strobes.delete();
		host_write({UPLOAD_NIBBLE, 19'h00123}, 16'hBEEF, 2'b11);
		repeat (3) @(posedge clk_sys);
		if (strobes.size() != 0)
		begin
			$display("Upload to an unmapped area still gave a strobe");
			errors = errors + 1;
		end
		report("direct upload", start_err);

		// Two sectors on the reset credits
		start_err = errors;
		load_sector(0);
		load_sector(1);
		wait_swaps(1);
		check("credit_count", 32'(credit_count), 0);
		wait_swaps(2);
		check("credit_count", 32'(credit_count), 1);
		report("sector loads and swaps", start_err);

		for (int r = 0; r < NROWS; r++)
			run_row(r);

		// No swap while the write bank is empty, then the third sector lands
		start_err = errors;
		check("sr_count", 32'(sr_count), 2);
		load_sector(2);
		wait_swaps(3);
		check("credit_count", 32'(credit_count), 2);
		report("third sector after credit", start_err);

		$display("Tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, errors);
		if (errors == 0 && tests_fail == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sources.f
logic/cdsys_pkg.sv
logic/xfer_bus_if.sv
logic/host_regs.sv
logic/sector_cache.sv
logic/dma_engine.sv
logic/xfer_arbiter.sv
logic/cd_xfer_top.sv
testbench/cd_xfer_chk.sv
testbench/tb_cd_xfer.sv

// File: Makefile
# Verilator build and run for the transfer controller testbench

VERILATOR ?= verilator
TOP       ?= tb_cd_xfer
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
